/* hw/rv_isa_pkg.sv */
package rv_isa_pkg;

  // Major opcodes of the base integer set
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LOAD   = 7'b0000011,
    OPC_JALR   = 7'b1100111,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  typedef enum logic [2:0] {
    F3_ADD  = 3'b000,
    F3_SLL  = 3'b001,
    F3_SLT  = 3'b010,
    F3_SLTU = 3'b011,
    F3_XOR  = 3'b100,
    F3_SR   = 3'b101, // Shared by logical and arithmetic right shift
    F3_OR   = 3'b110,
    F3_AND  = 3'b111
  } funct3_e;

  typedef enum logic [2:0] {
    FMT_R,
    FMT_I,
    FMT_S,
    FMT_B,
    FMT_U,
    FMT_J,
    FMT_NONE
  } format_e;

endpackage

/* hw/rv_core_pkg.sv */
package rv_core_pkg;

  // Operations the execute stage knows about
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B // Forwards operand b untouched
  } alu_op_e;

  parameter int REG_COUNT_DEF = 32;

endpackage

/* hw/stage_if.sv */
`timescale 1ns/10ps

interface dec_exe_if;
  import rv_core_pkg::*;

  logic        valid;     // One cycle per instruction
  logic [31:0] operand_a;
  logic [31:0] operand_b;
  alu_op_e     alu_op;
  logic [4:0]  rd;
  logic        illegal;

  modport master (output valid, operand_a, operand_b, alu_op, rd, illegal);
  modport slave  (input  valid, operand_a, operand_b, alu_op, rd, illegal);
endinterface

interface exe_res_if;
  logic        valid;
  logic [31:0] result;
  logic [4:0]  rd;
  logic        illegal;

  modport master (output valid, result, rd, illegal);
  modport slave  (input  valid, result, rd, illegal);
endinterface

/* hw/reg_file.sv */
`timescale 1ns/10ps

module reg_file #(
  parameter int REG_COUNT = rv_core_pkg::REG_COUNT_DEF
) (
  input  logic        clk,
  input  logic        arst_n_i,
  input  logic [4:0]  rs1_i,
  input  logic [4:0]  rs2_i,
  output logic [31:0] rd1_o,
  output logic [31:0] rd2_o,
  input  logic        wr_en_i,
  input  logic [4:0]  wr_addr_i,
  input  logic [31:0] wr_data_i
);

  logic [31:0] regs [REG_COUNT];

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      for (int i = 0; i < REG_COUNT; i++)
        regs[i] <= '0;
    end
    else if (wr_en_i && (wr_addr_i != 5'd0) && (wr_addr_i < REG_COUNT))
      regs[wr_addr_i] <= wr_data_i;
  end

  // x0 and missing registers read as zero
  assign rd1_o = ((rs1_i != 5'd0) && (rs1_i < REG_COUNT)) ? regs[rs1_i] : '0;
  assign rd2_o = ((rs2_i != 5'd0) && (rs2_i < REG_COUNT)) ? regs[rs2_i] : '0;

  // Writeback must already filter out x0 destinations
  a_no_x0_write : assert property (
    @(posedge clk) disable iff (!arst_n_i)
    wr_en_i |-> (wr_addr_i != 5'd0)
  );

endmodule

/* hw/instr_decode.sv */
`timescale 1ns/10ps

module instr_decode #(
  parameter int REG_COUNT = rv_core_pkg::REG_COUNT_DEF
) (
  input  logic        clk,
  input  logic        arst_n_i,
  input  logic        instr_req_i,
  input  logic [31:0] instr_i,
  input  logic        done_i,
  output logic [4:0]  rs1_o,
  output logic [4:0]  rs2_o,
  input  logic [31:0] rd1_i,
  input  logic [31:0] rd2_i,
  dec_exe_if.master   dec
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  opcode_e     opcode;
  funct3_e     funct3;
  format_e     fmt;
  logic [6:0]  funct7;
  logic [4:0]  rd;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  logic [31:0] imm;
  logic [31:0] op_a;
  logic [31:0] op_b;
  alu_op_e     alu_op;
  logic        illegal;
  logic        busy;
  logic        done_q;
  logic        capture;

  // Maps funct3 to an ALU operation with alt selecting SUB or SRA
  function automatic alu_op_e alu_from_f3(funct3_e f3, logic alt, logic sub_ok);
    alu_op_e op;
    case (f3)
      F3_ADD:  op = (alt && sub_ok) ? ALU_SUB : ALU_ADD;
      F3_SLL:  op = ALU_SLL;
      F3_SLT:  op = ALU_SLT;
      F3_SLTU: op = ALU_SLTU;
      F3_XOR:  op = ALU_XOR;
      F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:   op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = funct3_e'(instr_i[14:12]);
  assign funct7 = instr_i[31:25];
  assign rs1_o  = instr_i[19:15];
  assign rs2_o  = instr_i[24:20];
  assign rd     = (instr_i[11:7] < REG_COUNT) ? instr_i[11:7] : 5'd0; // Missing registers are never written

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  always_comb
  begin
    case (opcode)
      OPC_OP:                         fmt = FMT_R;
      OPC_OP_IMM, OPC_LOAD, OPC_JALR: fmt = FMT_I;
      OPC_STORE:                      fmt = FMT_S;
      OPC_BRANCH:                     fmt = FMT_B;
      OPC_LUI, OPC_AUIPC:             fmt = FMT_U;
      OPC_JAL:                        fmt = FMT_J;
      default:                        fmt = FMT_NONE;
    endcase
  end

  always_comb
  begin
    case (fmt)
      FMT_I:   imm = imm_i;
      FMT_S:   imm = imm_s;
      FMT_B:   imm = imm_b;
      FMT_U:   imm = imm_u;
      FMT_J:   imm = imm_j;
      default: imm = '0;
    endcase
  end

  always_comb
  begin
    op_a    = rd1_i;
    op_b    = rd2_i;
    alu_op  = ALU_ADD;
    illegal = 1'b0;
    case (opcode)
      OPC_OP:
        alu_op = alu_from_f3(funct3, funct7[5], 1'b1);
      OPC_OP_IMM:
      begin
        op_b   = imm;
        alu_op = alu_from_f3(funct3, imm[10], 1'b0); // Bit 10 marks SRAI
      end
      OPC_LUI:
      begin
        op_b   = imm;
        alu_op = ALU_PASS_B;
      end
      OPC_AUIPC:
      begin
        op_a = '0; // No fetch, so the program counter stays at zero
        op_b = imm;
      end
      default:
        illegal = 1'b1;
    endcase
  end

  assign capture = instr_req_i && !busy && !done_i;

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      busy      <= 1'b0;
      done_q    <= 1'b0;
      dec.valid <= 1'b0;
    end
    else
    begin
      dec.valid <= capture;
      done_q    <= done_i;
      if (capture)
        busy <= 1'b1;
      else if (done_q && !done_i)
        busy <= 1'b0; // Handshake closed
    end
  end

  always_ff @(posedge clk)
  begin
    if (capture)
    begin
      dec.operand_a <= op_a;
      dec.operand_b <= op_b;
      dec.alu_op    <= alu_op;
      dec.rd        <= rd;
      dec.illegal   <= illegal;
    end
  end

  // The host must hold the instruction until it sees the acknowledge
  a_instr_stable : assert property (
    @(posedge clk) disable iff (!arst_n_i)
    instr_req_i && $past(instr_req_i) && busy |-> $stable(instr_i)
  );

endmodule

/* hw/alu_execute.sv */
`timescale 1ns/10ps

module alu_execute (
  input logic       clk,
  input logic       arst_n_i,
  dec_exe_if.slave  dec,
  exe_res_if.master exe
);
  import rv_core_pkg::*;

  logic [31:0] alu_res;
  logic [4:0]  shamt;

  assign shamt = dec.operand_b[4:0];

  always_comb
  begin
    case (dec.alu_op)
      ALU_ADD:    alu_res = dec.operand_a + dec.operand_b;
      ALU_SUB:    alu_res = dec.operand_a - dec.operand_b;
      ALU_SLL:    alu_res = dec.operand_a << shamt;
      ALU_SLT:    alu_res = {31'b0, $signed(dec.operand_a) < $signed(dec.operand_b)};
      ALU_SLTU:   alu_res = {31'b0, dec.operand_a < dec.operand_b};
      ALU_XOR:    alu_res = dec.operand_a ^ dec.operand_b;
      ALU_SRL:    alu_res = dec.operand_a >> shamt;
      ALU_SRA:    alu_res = $unsigned($signed(dec.operand_a) >>> shamt);
      ALU_OR:     alu_res = dec.operand_a | dec.operand_b;
      ALU_AND:    alu_res = dec.operand_a & dec.operand_b;
      ALU_PASS_B: alu_res = dec.operand_b;
      default:    alu_res = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      exe.valid <= 1'b0;
    else
      exe.valid <= dec.valid;
  end

  always_ff @(posedge clk)
  begin
    if (dec.valid)
    begin
      exe.result  <= alu_res;
      exe.rd      <= dec.rd;
      exe.illegal <= dec.illegal;
    end
  end

  // Decode must only hand over operations this stage implements
  a_alu_op_known : assert property (
    @(posedge clk) disable iff (!arst_n_i)
    dec.valid |-> dec.alu_op inside {ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
                                     ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B}
  );

endmodule

/* hw/result_writeback.sv */
`timescale 1ns/10ps

module result_writeback (
  input  logic        clk,
  input  logic        arst_n_i,
  exe_res_if.slave    exe,
  input  logic        instr_req_i,
  output logic        instr_ack_o,
  output logic [31:0] result_o,
  output logic        illegal_o,
  output logic        done_o,
  output logic        wr_en_o,
  output logic [4:0]  wr_addr_o,
  output logic [31:0] wr_data_o
);

  logic        ack_q;
  logic [31:0] result_q;
  logic        illegal_q;

  // Illegal instructions and x0 destinations leave the registers alone
  assign wr_en_o   = exe.valid && !exe.illegal && (exe.rd != 5'd0);
  assign wr_addr_o = exe.rd;
  assign wr_data_o = exe.result;

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      ack_q     <= 1'b0;
      result_q  <= '0;
      illegal_q <= 1'b0;
    end
    else if (exe.valid)
    begin
      ack_q     <= 1'b1;
      result_q  <= exe.illegal ? '0 : exe.result;
      illegal_q <= exe.illegal;
    end
    else if (ack_q && !instr_req_i)
      ack_q <= 1'b0; // Host released the request
  end

  assign instr_ack_o = ack_q;
  assign done_o      = ack_q;
  assign result_o    = result_q;
  assign illegal_o   = illegal_q;

  // Only an instruction the host actually requested may be acknowledged
  a_ack_needs_req : assert property (
    @(posedge clk) disable iff (!arst_n_i)
    $rose(instr_ack_o) |-> $past(instr_req_i)
  );

endmodule

/* hw/rv_core_top.sv */
`timescale 1ns/10ps

module rv_core_top #(
  parameter int REG_COUNT = rv_core_pkg::REG_COUNT_DEF
) (
  input  logic        clk,
  input  logic        arst_n_i,
  input  logic        instr_req_i,
  input  logic [31:0] instr_i,
  output logic        instr_ack_o,
  output logic [31:0] result_o,
  output logic        illegal_o
);

  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [31:0] rd1;
  logic [31:0] rd2;
  logic        wr_en;
  logic [4:0]  wr_addr;
  logic [31:0] wr_data;
  logic        done;

  dec_exe_if dec_bus ();
  exe_res_if exe_bus ();

  reg_file #(
    .REG_COUNT (REG_COUNT)
  ) i_reg_file (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .rs1_i     (rs1),
    .rs2_i     (rs2),
    .rd1_o     (rd1),
    .rd2_o     (rd2),
    .wr_en_i   (wr_en),
    .wr_addr_i (wr_addr),
    .wr_data_i (wr_data)
  );

  instr_decode #(
    .REG_COUNT (REG_COUNT)
  ) i_instr_decode (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .instr_req_i (instr_req_i),
    .instr_i     (instr_i),
    .done_i      (done),
    .rs1_o       (rs1),
    .rs2_o       (rs2),
    .rd1_i       (rd1),
    .rd2_i       (rd2),
    .dec         (dec_bus.master)
  );

  alu_execute i_alu_execute (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .dec      (dec_bus.slave),
    .exe      (exe_bus.master)
  );

  result_writeback i_result_writeback (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .exe         (exe_bus.slave),
    .instr_req_i (instr_req_i),
    .instr_ack_o (instr_ack_o),
    .result_o    (result_o),
    .illegal_o   (illegal_o),
    .done_o      (done),
    .wr_en_o     (wr_en),
    .wr_addr_o   (wr_addr),
    .wr_data_o   (wr_data)
  );

endmodule

/* verification/tb_checker.sv */
`timescale 1ns/10ps

module tb_checker (
  input  logic         clk,
  input  logic         arst_n_i,
  input  logic         req_i,
  input  logic [31:0]  instr_i,
  input  logic         ack_i,
  input  logic [31:0]  result_i,
  input  logic         illegal_i,
  input  logic [127:0] test_name_i,
  output int           data_errs_o,
  output int           hs_errs_o,
  output int           acks_o
);

  logic [31:0] ref_regs [32];
  logic [31:0] held_instr;
  logic [31:0] held_res;
  logic [31:0] exp_res;
  logic        exp_ill;
  logic        pending;
  logic        ack_seen;
  logic        req_seen;

  // Expected outcome of one instruction that also updates the register model
  function automatic void rv_ref_exec(input logic [31:0] instr, output logic [31:0] res,
                                      output logic ill);
    logic [31:0] a;
    logic [31:0] b;
    logic        alt;
    logic        is_r;
    a    = ref_regs[instr[19:15]];
    b    = ref_regs[instr[24:20]];
    alt  = instr[30]; // funct7 bit 5, or bit 10 of the I immediate
    is_r = (instr[6:0] == 7'b0110011);
    ill  = 1'b0;
    res  = 32'd0;
    if (instr[6:0] == 7'b0010011)
      b = {{20{instr[31]}}, instr[31:20]};
    case (instr[6:0])
      7'b0110011, 7'b0010011:
        case (instr[14:12])
          3'd0:    res = (alt && is_r) ? a - b : a + b;
          3'd1:    res = a << b[4:0];
          3'd2:    res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          3'd3:    res = (a < b) ? 32'd1 : 32'd0;
          3'd4:    res = a ^ b;
          3'd5:    res = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
          3'd6:    res = a | b;
          default: res = a & b;
        endcase
      7'b0110111, 7'b0010111:
        res = {instr[31:12], 12'd0}; // AUIPC adds a program counter of zero
      default:
        ill = 1'b1;
    endcase
    if (!ill && (instr[11:7] != 5'd0))
      ref_regs[instr[11:7]] = res;
  endfunction

  always @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      for (int i = 0; i < 32; i++)
        ref_regs[i] = 32'd0;
      data_errs_o = 0;
      hs_errs_o   = 0;
      acks_o      = 0;
      pending     = 1'b0;
      ack_seen    = 1'b0;
      req_seen    = 1'b0;
      held_instr  = 32'd0;
      held_res    = 32'd0;
    end
    else
    begin
      if (req_i && !ack_i && !pending)
      begin
        held_instr = instr_i; // The instruction is stable during the request phase
        pending    = 1'b1;
      end
      if (ack_i && !ack_seen)
      begin
        acks_o++;
        if (!pending || !req_seen)
        begin
          hs_errs_o++;
          $display("Handshake error in %0s: acknowledge rose without an open request",
                   test_name_i);
        end
        pending = 1'b0;
        rv_ref_exec(held_instr, exp_res, exp_ill);
        if (result_i !== exp_res)
        begin
          data_errs_o++;
          $display("[ERROR] %0s: result of %h expected %h, actual %h",
                   test_name_i, held_instr, exp_res, result_i);
        end
        if (illegal_i !== exp_ill)
        begin
          data_errs_o++;
          $display("[ERROR] %0s: illegal flag of %h expected %b, actual %b",
                   test_name_i, held_instr, exp_ill, illegal_i);
        end
        held_res = result_i;
      end
      else if (ack_i && (result_i !== held_res))
      begin
        hs_errs_o++;
        $display("Handshake error in %0s: result changed while acknowledge was high",
                 test_name_i);
      end
      if (!ack_i && ack_seen && req_seen)
      begin
        hs_errs_o++;
        $display("Handshake error in %0s: acknowledge fell while the request was high",
                 test_name_i);
      end
      ack_seen = ack_i;
      req_seen = req_i;
    end
  end

endmodule

/* verification/tb_top.sv */
`timescale 1ns/10ps

module tb_top;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 16;
  localparam int HS_LIMIT     = 40; // Cycles allowed for one handshake phase
  localparam int N_IMM        = 6;
  localparam int N_OPIMM      = 10;
  localparam int N_RTYPE      = 60;
  localparam int N_X0         = 6;
  localparam int N_ILL        = 20;
  localparam int N_SLOW       = 8;
  localparam int N_INSTR      = N_IMM + N_OPIMM + N_RTYPE + N_X0 + N_ILL + N_SLOW;

  localparam logic [6:0] OP_REG   = 7'b0110011;
  localparam logic [6:0] OP_IMM   = 7'b0010011;
  localparam logic [6:0] OP_LUI   = 7'b0110111;
  localparam logic [6:0] OP_AUIPC = 7'b0010111;
  // Load, store, branch, JAL and JALR
  localparam logic [6:0] BAD_OPC [5] = '{7'b0000011, 7'b0100011, 7'b1100011,
                                         7'b1101111, 7'b1100111};

  logic         clk;
  logic         arst_n_i;
  logic         instr_req_i;
  logic [31:0]  instr_i;
  logic         instr_ack_o;
  logic [31:0]  result_o;
  logic         illegal_o;
  logic [127:0] test_name;
  int           data_errs;
  int           hs_errs;
  int           acks;
  int           sent;
  int           drv_errs;

  rv_core_top #(
    .REG_COUNT (32)
  ) i_dut (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .instr_req_i (instr_req_i),
    .instr_i     (instr_i),
    .instr_ack_o (instr_ack_o),
    .result_o    (result_o),
    .illegal_o   (illegal_o)
  );

  tb_checker i_checker (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .req_i       (instr_req_i),
    .instr_i     (instr_i),
    .ack_i       (instr_ack_o),
    .result_i    (result_o),
    .illegal_i   (illegal_o),
    .test_name_i (test_name),
    .data_errs_o (data_errs),
    .hs_errs_o   (hs_errs),
    .acks_o      (acks)
  );

  function automatic logic [31:0] utype_word(logic [6:0] opc, logic [4:0] rd,
                                             logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] opimm_word(logic [4:0] rd, logic [2:0] f3,
                                             logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, OP_IMM};
  endfunction

  function automatic logic [31:0] rtype_word(logic [4:0] rd, logic [2:0] f3,
                                             logic [4:0] rs1, logic [4:0] rs2, logic alt);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OP_REG};
  endfunction

  // Host side of the four-phase handshake that starts on a falling edge
  task automatic send_instr(input logic [31:0] word, input int max_delay);
    int waited;
    repeat ($urandom_range(max_delay, 0)) @(negedge clk);
    instr_i     = word;
    instr_req_i = 1'b1;
    waited      = 0;
    while (!instr_ack_o && (waited < HS_LIMIT))
    begin
      @(negedge clk);
      waited++;
    end
    if (!instr_ack_o)
    begin
      $display("No acknowledge arrived for instruction %h", word);
      drv_errs++;
    end
    repeat ($urandom_range(max_delay, 0)) @(negedge clk);
    instr_req_i = 1'b0;
    waited      = 0;
    while (instr_ack_o && (waited < HS_LIMIT))
    begin
      @(negedge clk);
      waited++;
    end
    if (instr_ack_o)
    begin
      $display("Acknowledge stayed high after the request for %h was dropped", word);
      drv_errs++;
    end
    sent++;
  endtask

  // LUI and ADDI pair with the upper part rounded for the sign of the low 12 bits
  task automatic load_value(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h800;
    send_instr(utype_word(OP_LUI, rd, upper[31:12]), 0);
    send_instr(opimm_word(rd, 3'd0, rd, value[11:0]), 0);
  endtask

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    logic [31:0] rnd;
    logic [31:0] val_a;
    logic [31:0] val_b;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic        alt;
    rnd         = $urandom(45);
    arst_n_i    = 1'b0;
    instr_req_i = 1'b0;
    instr_i     = 32'd0;
    sent        = 0;
    drv_errs    = 0;
    test_name   = 128'("reset");
    repeat (RESET_CYCLES) @(negedge clk);
    arst_n_i = 1'b1;
    repeat (2) @(negedge clk);

    test_name = 128'("imm_forms");
    send_instr(utype_word(OP_LUI, 5'd1, 20'h12345), 0);
    send_instr(utype_word(OP_LUI, 5'd2, 20'hFFFFF), 0);
    send_instr(utype_word(OP_LUI, 5'd3, 20'h80000), 0);
    send_instr(utype_word(OP_AUIPC, 5'd4, 20'h00ABC), 0);
    send_instr(utype_word(OP_AUIPC, 5'd5, 20'hF0F0F), 0);
    send_instr(utype_word(OP_LUI, 5'd6, 20'h00007), 0);

    test_name = 128'("op_imm");
    send_instr(opimm_word(5'd7, 3'd0, 5'd1, 12'hFFF), 0);
    send_instr(opimm_word(5'd8, 3'd2, 5'd2, 12'hFFB), 0);
    send_instr(opimm_word(5'd9, 3'd3, 5'd1, 12'hFFF), 0);
    send_instr(opimm_word(5'd10, 3'd4, 5'd3, 12'h555), 0);
    send_instr(opimm_word(5'd11, 3'd6, 5'd4, 12'hF00), 0);
    send_instr(opimm_word(5'd12, 3'd7, 5'd5, 12'h7F0), 0);
    send_instr(opimm_word(5'd13, 3'd1, 5'd1, 12'h004), 0);
    send_instr(opimm_word(5'd14, 3'd5, 5'd2, 12'h008), 0);
    send_instr(opimm_word(5'd15, 3'd5, 5'd3, 12'h40C), 0); // SRAI by 12
    send_instr(opimm_word(5'd16, 3'd0, 5'd6, 12'h800), 0);

    test_name = 128'("r_type");
    for (int k = 0; k < 10; k++)
    begin
      val_a = $urandom();
      val_b = $urandom();
      f3    = (k < 8) ? k[2:0] : ((k == 8) ? 3'd0 : 3'd5);
      alt   = (k >= 8); // Last two are SUB and SRA
      load_value(5'd20, val_a);
      load_value(5'd21, val_b);
      send_instr(rtype_word(5'd22, f3, 5'd20, 5'd21, alt), 0);
      send_instr(opimm_word(5'd23, 3'd0, 5'd22, 12'h000), 0);
    end

    test_name = 128'("x0_zero");
    send_instr(opimm_word(5'd0, 3'd0, 5'd1, 12'h005), 0);
    send_instr(opimm_word(5'd25, 3'd0, 5'd0, 12'h000), 0);
    send_instr(utype_word(OP_LUI, 5'd0, 20'hABCDE), 0);
    send_instr(opimm_word(5'd25, 3'd0, 5'd0, 12'h000), 0);
    send_instr(rtype_word(5'd0, 3'd0, 5'd1, 5'd2, 1'b0), 0);
    send_instr(opimm_word(5'd25, 3'd0, 5'd0, 12'h000), 0);

    test_name = 128'("illegal");
    for (int k = 0; k < 10; k++)
    begin
      if (k < 5)
        opc = BAD_OPC[k];
      else
      begin
        do
        begin
          rnd = $urandom();
          opc = rnd[6:0];
        end
        while (opc inside {OP_REG, OP_IMM, OP_LUI, OP_AUIPC, 7'b0000011, 7'b0100011,
                           7'b1100011, 7'b1101111, 7'b1100111});
      end
      rnd = $urandom();
      send_instr({rnd[31:12], 5'd1, opc}, 0); // Targets x1, which must keep its value
      send_instr(opimm_word(5'd26, 3'd0, 5'd1, 12'h000), 0);
    end

    test_name = 128'("slow_host");
    for (int k = 0; k < N_SLOW; k++)
    begin
      rnd = $urandom();
      f3  = rnd[2:0];
      alt = rnd[3] && ((f3 == 3'd0) || (f3 == 3'd5));
      send_instr(rtype_word(rnd[8:4], f3, rnd[13:9], rnd[18:14], alt), 5);
    end

    repeat (4) @(negedge clk);
    if (acks != sent)
    begin
      $display("Saw %0d acknowledges for %0d instructions sent", acks, sent);
      drv_errs++;
    end
    $display("Errors: %0d result, %0d handshake, %0d driver", data_errs, hs_errs, drv_errs);
    if ((data_errs + hs_errs + drv_errs) == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

  // A handshake takes six cycles and ten per instruction leave room for the slow host
  initial
  begin
    #(CLK_PERIOD * (RESET_CYCLES + N_INSTR * 10));
    $display("Watchdog expired with %0d of %0d instructions done", sent, N_INSTR);
    $display("Errors: %0d result, %0d handshake, %0d driver", data_errs, hs_errs, drv_errs);
    $display("Something failed");
    $finish;
  end

endmodule

/* sim.f */
hw/rv_isa_pkg.sv
hw/rv_core_pkg.sv
hw/stage_if.sv
hw/reg_file.sv
hw/instr_decode.sv
hw/alu_execute.sv
hw/result_writeback.sv
hw/rv_core_top.sv
verification/tb_checker.sv
verification/tb_top.sv

/* Makefile */
# Verilator simulation of the RV32I execution core

VERILATOR ?= verilator
TOP       ?= tb_top
BUILD_DIR ?= obj_dir
FILELIST  ?= sim.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
